// ==== arm_isa_pkg.sv ====
`default_nettype none

package arm_isa_pkg;

        localparam int INSTR_W = 32;

        // ----------------------------------------
        // Field encodings
        // ----------------------------------------

        typedef enum logic [3:0]
        {
                EQ, NE, CS, CC, MI, PL, VS, VC,
                HI, LS, GE, LT, GT, LE, AL, NV
        } cond_e;

        typedef enum logic [3:0]
        {
                OP_AND, OP_EOR, OP_SUB, OP_RSB, OP_ADD, OP_ADC, OP_SBC, OP_RSC,
                OP_TST, OP_TEQ, OP_CMP, OP_CMN, OP_ORR, OP_MOV, OP_BIC, OP_MVN
        } dp_opcode_e;

        typedef enum logic [1:0]
        {
                SH_LSL, SH_LSR, SH_ASR, SH_ROR
        } shift_e;

        typedef enum logic [2:0]
        {
                DP_IMM, DP_SHIFT, BRANCH, MUL, SWI, UND
        } instr_class_e;

        // ----------------------------------------
        // Instruction word views
        // ----------------------------------------

        // Register operand of a data processing word, bits 11:0
        typedef struct packed
        {
                logic [4:0]     shamt;
                shift_e         shtype;
                logic           bit4;
                logic [3:0]     rm;
        } dp_operand_t;

        typedef struct packed
        {
                cond_e          cond;
                logic [1:0]     cls;
                logic           imm;
                dp_opcode_e     opcode;
                logic           s;
                logic [3:0]     rn;
                logic [3:0]     rd;
                dp_operand_t    operand;
        } dp_fmt_t;

        typedef struct packed
        {
                cond_e          cond;
                logic [2:0]     cls;
                logic           link;
                logic [23:0]    offset;
        } branch_fmt_t;

        // Rd and Rn sit swapped compared to data processing
        typedef struct packed
        {
                cond_e          cond;
                logic [5:0]     zero;
                logic           accum;
                logic           s;
                logic [3:0]     rd;
                logic [3:0]     rn;
                logic [3:0]     rs;
                logic [3:0]     marker;
                logic [3:0]     rm;
        } mul_fmt_t;

        typedef union packed
        {
                dp_fmt_t                dp;
                branch_fmt_t            br;
                mul_fmt_t               mul;
                logic [INSTR_W-1:0]     raw;
        } instr_word_u;

        // Decoded fields carried from stage 1 to stage 2
        typedef struct packed
        {
                instr_class_e           cls;
                cond_e                  cond;
                dp_opcode_e             opcode;
                logic                   s_flag;
                logic                   link;
                logic                   accum;
                logic [3:0]             rd;
                logic [3:0]             rn;
                logic [3:0]             rm;
                logic [3:0]             rs;
                shift_e                 shtype;
                logic [4:0]             shamt;
                logic [INSTR_W-1:0]     value;
        } decoded_instr_t;

endpackage

`default_nettype wire

// ==== disasm_text_pkg.sv ====
`default_nettype none

package disasm_text_pkg;

        localparam int CHAR_W      = 8;
        localparam int FIELD_CHARS = 4;
        localparam int COND_CHARS  = 2;
        localparam int LINE_CHARS  = 24;

        typedef logic [CHAR_W-1:0] char_t;

        // Leftmost character sits at the highest index
        typedef char_t [FIELD_CHARS-1:0] field_t;
        typedef char_t [COND_CHARS-1:0]  cond_text_t;
        typedef char_t [LINE_CHARS-1:0]  disasm_line_t;

        typedef struct packed
        {
                field_t         mnem;
                cond_text_t     cond;
        } mnem_text_t;

        typedef struct packed
        {
                field_t         a;
                field_t         b;
                field_t         c;
                field_t         d;
        } operand_text_t;

        // ----------------------------------------
        // Character constants
        // ----------------------------------------

        localparam char_t  ASCII_SPACE = 8'h20;
        localparam char_t  ASCII_TILDE = 8'h7E;
        localparam field_t BLANK_FIELD = {FIELD_CHARS{ASCII_SPACE}};

endpackage

`default_nettype wire

// ==== instr_classify.sv ====
`timescale 1ns/1ps
`default_nettype none

module instr_classify
(
        input  wire                             i_clk,
        input  wire                             i_reset,
        input  arm_isa_pkg::instr_word_u        i_instruction,
        input  wire                             i_dav,
        output arm_isa_pkg::decoded_instr_t     o_decoded,
        output logic                            o_decoded_valid
);

        import arm_isa_pkg::*;

        decoded_instr_t decoded_next;

        // ----------------------------------------
        // Classification
        // ----------------------------------------

        always_comb
        begin
                decoded_next       = '0;
                decoded_next.cls   = UND;
                decoded_next.cond  = i_instruction.dp.cond;
                decoded_next.value = i_instruction.raw;

                if (i_instruction.dp.cond == NV)
                begin
                        decoded_next.cls = UND;
                end
                else if (i_instruction.mul.zero == 6'b000000 &&
                         i_instruction.mul.marker == 4'b1001)
                begin
                        decoded_next.cls    = MUL;
                        decoded_next.accum  = i_instruction.mul.accum;
                        decoded_next.s_flag = i_instruction.mul.s;
                        decoded_next.rd     = i_instruction.mul.rd;
                        decoded_next.rn     = i_instruction.mul.rn;
                        decoded_next.rs     = i_instruction.mul.rs;
                        decoded_next.rm     = i_instruction.mul.rm;
                end
                else if (i_instruction.br.cls == 3'b101)
                begin
                        decoded_next.cls   = BRANCH;
                        decoded_next.link  = i_instruction.br.link;
                        decoded_next.value = {8'h00, i_instruction.br.offset};
                end
                else if (i_instruction.raw[27:24] == 4'b1111)
                begin
                        // Comment field lives where the branch offset would
                        decoded_next.cls   = SWI;
                        decoded_next.value = {8'h00, i_instruction.br.offset};
                end
                else if (i_instruction.dp.cls == 2'b00)
                begin
                        decoded_next.opcode = i_instruction.dp.opcode;
                        decoded_next.s_flag = i_instruction.dp.s;
                        decoded_next.rn     = i_instruction.dp.rn;
                        decoded_next.rd     = i_instruction.dp.rd;
                        decoded_next.rm     = i_instruction.dp.operand.rm;
                        decoded_next.shtype = i_instruction.dp.operand.shtype;
                        decoded_next.shamt  = i_instruction.dp.operand.shamt;

                        // Test opcodes without S are the status register moves
                        if (i_instruction.dp.opcode inside {OP_TST, OP_TEQ, OP_CMP, OP_CMN} &&
                            !i_instruction.dp.s)
                                decoded_next.cls = UND;
                        else if (!i_instruction.dp.imm && i_instruction.dp.operand.bit4)
                                decoded_next.cls = UND;
                        else if (i_instruction.dp.imm)
                        begin
                                decoded_next.cls   = DP_IMM;
                                decoded_next.value = {20'h00000, i_instruction.dp.operand};
                        end
                        else
                                decoded_next.cls = DP_SHIFT;
                end
        end

        // ----------------------------------------
        // Stage 1 register
        // ----------------------------------------

        always_ff @(posedge i_clk)
        begin
                if (i_reset)
                        o_decoded_valid <= 1'b0;
                else
                        o_decoded_valid <= i_dav;
        end

        // Payload holds over idle cycles
        always_ff @(posedge i_clk)
        begin
                if (i_dav)
                        o_decoded <= decoded_next;
        end

        a_class_legal : assert property (@(posedge i_clk) disable iff (i_reset)
                o_decoded_valid |-> o_decoded.cls inside {DP_IMM, DP_SHIFT, BRANCH, MUL, SWI, UND})
                else $error("instr_classify: illegal class %0d", o_decoded.cls);

endmodule

`default_nettype wire

// ==== mnemonic_formatter.sv ====
`timescale 1ns/1ps
`default_nettype none

module mnemonic_formatter
(
        input  arm_isa_pkg::decoded_instr_t     i_decoded,
        output disasm_text_pkg::mnem_text_t     o_mnem
);

        import arm_isa_pkg::*;
        import disasm_text_pkg::*;

        typedef char_t [2:0] name3_t;

        char_t suffix;

        function automatic name3_t opcode_name(input dp_opcode_e opcode);
                case (opcode)
                OP_AND:  return "AND";
                OP_EOR:  return "EOR";
                OP_SUB:  return "SUB";
                OP_RSB:  return "RSB";
                OP_ADD:  return "ADD";
                OP_ADC:  return "ADC";
                OP_SBC:  return "SBC";
                OP_RSC:  return "RSC";
                OP_TST:  return "TST";
                OP_TEQ:  return "TEQ";
                OP_CMP:  return "CMP";
                OP_CMN:  return "CMN";
                OP_ORR:  return "ORR";
                OP_MOV:  return "MOV";
                OP_BIC:  return "BIC";
                default: return "MVN";
                endcase
        endfunction

        function automatic cond_text_t cond_name(input cond_e cond);
                case (cond)
                EQ:      return "EQ";
                NE:      return "NE";
                CS:      return "CS";
                CC:      return "CC";
                MI:      return "MI";
                PL:      return "PL";
                VS:      return "VS";
                VC:      return "VC";
                HI:      return "HI";
                LS:      return "LS";
                GE:      return "GE";
                LT:      return "LT";
                GT:      return "GT";
                LE:      return "LE";
                AL:      return "AL";
                default: return "NV";
                endcase
        endfunction

        always_comb
        begin
                suffix      = i_decoded.s_flag ? "S" : ASCII_SPACE;
                o_mnem.cond = cond_name(i_decoded.cond);

                case (i_decoded.cls)
                DP_IMM, DP_SHIFT:
                begin
                        // Compare opcodes always set flags, so no S is printed
                        if (i_decoded.opcode inside {OP_TST, OP_TEQ, OP_CMP, OP_CMN})
                                suffix = ASCII_SPACE;
                        o_mnem.mnem = {opcode_name(i_decoded.opcode), suffix};
                end
                BRANCH:
                        o_mnem.mnem = i_decoded.link ? "BL  " : "B   ";
                MUL:
                        o_mnem.mnem = {i_decoded.accum ? "MLA" : "MUL", suffix};
                SWI:
                        o_mnem.mnem = "SWI ";
                default:
                begin
                        o_mnem.mnem = "UND ";
                        o_mnem.cond = {ASCII_SPACE, ASCII_SPACE};
                end
                endcase
        end

endmodule

`default_nettype wire

// ==== operand_formatter.sv ====
`timescale 1ns/1ps
`default_nettype none

module operand_formatter
(
        input  arm_isa_pkg::decoded_instr_t     i_decoded,
        output disasm_text_pkg::operand_text_t  o_operands
);

        import arm_isa_pkg::*;
        import disasm_text_pkg::*;

        typedef char_t [7:0] hex_word_t;

        hex_word_t value_hex;

        // ----------------------------------------
        // Lookup tables
        // ----------------------------------------

        function automatic char_t hex_char(input logic [3:0] nibble);
                if (nibble < 4'd10)
                        return 8'h30 + {4'h0, nibble};
                else
                        return 8'h37 + {4'h0, nibble};
        endfunction

        // Digit 7 is the most significant nibble
        function automatic hex_word_t hex_digits(input logic [INSTR_W-1:0] value);
                hex_word_t digits;

                for (int i = 0; i < 8; i++)
                begin
                        digits[i] = hex_char(value[4*i +: 4]);
                end
                return digits;
        endfunction

        function automatic field_t reg_name(input logic [3:0] num);
                case (num)
                4'd0:    return "R0  ";
                4'd1:    return "R1  ";
                4'd2:    return "R2  ";
                4'd3:    return "R3  ";
                4'd4:    return "R4  ";
                4'd5:    return "R5  ";
                4'd6:    return "R6  ";
                4'd7:    return "R7  ";
                4'd8:    return "R8  ";
                4'd9:    return "R9  ";
                4'd10:   return "R10 ";
                4'd11:   return "R11 ";
                4'd12:   return "R12 ";
                4'd13:   return "SP  ";
                4'd14:   return "LR  ";
                default: return "PC  ";
                endcase
        endfunction

        function automatic cond_text_t shift_code(input shift_e shtype);
                case (shtype)
                SH_LSL:  return "LL";
                SH_LSR:  return "LR";
                SH_ASR:  return "AR";
                default: return "RR";
                endcase
        endfunction

        // ----------------------------------------
        // Field layout per class
        // ----------------------------------------

        always_comb
        begin
                value_hex  = hex_digits(i_decoded.value);
                o_operands = {BLANK_FIELD, BLANK_FIELD, BLANK_FIELD, BLANK_FIELD};

                case (i_decoded.cls)
                DP_IMM:
                begin
                        o_operands.a = reg_name(i_decoded.rd);
                        o_operands.b = reg_name(i_decoded.rn);
                        o_operands.c = {"#", value_hex[2:0]};
                end
                DP_SHIFT:
                begin
                        o_operands.a = reg_name(i_decoded.rd);
                        o_operands.b = reg_name(i_decoded.rn);
                        o_operands.c = reg_name(i_decoded.rm);
                        o_operands.d = {shift_code(i_decoded.shtype),
                                        hex_char({3'b000, i_decoded.shamt[4]}),
                                        hex_char(i_decoded.shamt[3:0])};
                end
                BRANCH, SWI:
                        o_operands = {"#", value_hex[5:0], ASCII_SPACE, BLANK_FIELD, BLANK_FIELD};
                MUL:
                begin
                        o_operands.a = reg_name(i_decoded.rd);
                        o_operands.b = reg_name(i_decoded.rm);
                        o_operands.c = reg_name(i_decoded.rs);
                        if (i_decoded.accum)
                                o_operands.d = reg_name(i_decoded.rn);
                end
                default:
                        // Whole word for anything not decoded
                        o_operands = {"#", value_hex, ASCII_SPACE, ASCII_SPACE, ASCII_SPACE,
                                      BLANK_FIELD};
                endcase
        end

endmodule

`default_nettype wire

// ==== text_assembler.sv ====
`timescale 1ns/1ps
`default_nettype none

module text_assembler
(
        input  wire                             i_clk,
        input  wire                             i_reset,
        input  arm_isa_pkg::decoded_instr_t     i_decoded,
        input  wire                             i_decoded_valid,
        output disasm_text_pkg::disasm_line_t   o_text,
        output logic                            o_text_valid
);

        import disasm_text_pkg::*;

        mnem_text_t     mnem;
        operand_text_t  operands;
        disasm_line_t   line;

        function automatic logic line_printable(input disasm_line_t text);
                logic ok;

                ok = 1'b1;
                for (int i = 0; i < LINE_CHARS; i++)
                begin
                        if (text[i] < ASCII_SPACE || text[i] > ASCII_TILDE)
                                ok = 1'b0;
                end
                return ok;
        endfunction

        mnemonic_formatter u_mnem
        (
                .i_decoded      (i_decoded),
                .o_mnem         (mnem)
        );

        operand_formatter u_operands
        (
                .i_decoded      (i_decoded),
                .o_operands     (operands)
        );

        // Mnemonic, condition, two blank gap, then A to D
        assign line = {mnem.mnem, mnem.cond, ASCII_SPACE, ASCII_SPACE, operands};

        // ----------------------------------------
        // Stage 2 register
        // ----------------------------------------

        always_ff @(posedge i_clk)
        begin
                if (i_reset)
                        o_text_valid <= 1'b0;
                else
                        o_text_valid <= i_decoded_valid;
        end

        always_ff @(posedge i_clk)
        begin
                if (i_decoded_valid)
                        o_text <= line;
        end

        a_line_printable : assert property (@(posedge i_clk) disable iff (i_reset)
                o_text_valid |-> line_printable(o_text))
                else $error("text_assembler: non-printable character in \"%s\"", o_text);

endmodule

`default_nettype wire

// ==== arm_disasm_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module arm_disasm_top
(
        input  wire                             i_clk,
        input  wire                             i_reset,
        input  arm_isa_pkg::instr_word_u        i_instruction,
        input  wire                             i_dav,
        output disasm_text_pkg::disasm_line_t   o_text,
        output logic                            o_text_valid
);

        import arm_isa_pkg::*;

        decoded_instr_t decoded;
        logic           decoded_valid;

        // Stage 1 decodes the word
        instr_classify u_classify
        (
                .i_clk                  (i_clk),
                .i_reset                (i_reset),
                .i_instruction          (i_instruction),
                .i_dav                  (i_dav),
                .o_decoded              (decoded),
                .o_decoded_valid        (decoded_valid)
        );

        // Stage 2 formats the text line
        text_assembler u_assembler
        (
                .i_clk                  (i_clk),
                .i_reset                (i_reset),
                .i_decoded              (decoded),
                .i_decoded_valid        (decoded_valid),
                .o_text                 (o_text),
                .o_text_valid           (o_text_valid)
        );

endmodule

`default_nettype wire

// ==== tb_vectors.svh ====
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// Columns: test name, instruction word, expected 24-character line
// Line is mnemonic(4) condition(2) gap(2) then fields A B C D of 4 each

task automatic fill_table();
        // Idle cycles right after reset
        add_gap();
        add_gap();

        // ----------------------------------------
        // Data processing, all 16 opcodes
        // ----------------------------------------
        add_vector("and_imm",    32'hE20120FF, "AND AL  R2  R1  #0FF    ");
        add_vector("eors_imm",   32'h02334ABC, "EORSEQ  R4  R3  #ABC    ");
        add_vector("sub_lsl",    32'h10456187, "SUB NE  R6  R5  R7  LL03");
        add_vector("rsbs_lsr",   32'h2079AFA8, "RSBSCS  R10 R9  R8  LR1F");
        add_vector("add_asr",    32'h308DE84C, "ADD CC  LR  SP  R12 AR10");
        add_vector("adcs_ror",   32'h40B0B0EF, "ADCSMI  R11 R0  PC  RR01");
        add_vector("sbc_imm",    32'h52C23123, "SBC PL  R3  R2  #123    ");
        add_vector("rscs_imm",   32'h62F45800, "RSCSVS  R5  R4  #800    ");
        // Compare opcodes never show the S
        add_vector("tst_imm",    32'h7316000F, "TST VC  R0  R6  #00F    ");
        add_vector("teq_lsl",    32'h81310002, "TEQ HI  R0  R1  R2  LL00");
        add_vector("cmp_imm",    32'h935700FF, "CMP LS  R0  R7  #0FF    ");
        add_vector("cmn_asr",    32'hA1780149, "CMN GE  R0  R8  R9  AR02");
        add_vector("orr_imm",    32'hB389AFFF, "ORR LT  R10 R9  #FFF    ");
        add_vector("movs_lsr",   32'hC1B01222, "MOVSGT  R1  R0  R2  LR04");
        add_vector("bics_imm",   32'hD3DBC3A5, "BICSLE  R12 R11 #3A5    ");
        add_vector("mvn_ror",    32'hE1E03F64, "MVN AL  R3  R0  R4  RR1E");
        add_gap();

        // ----------------------------------------
        // Branch and SWI
        // ----------------------------------------
        add_vector("b_al",       32'hEA000010, "B   AL  #000010         ");
        add_vector("bl_ne",      32'h1BFFFFFE, "BL  NE  #FFFFFE         ");
        add_vector("b_gt",       32'hCA123456, "B   GT  #123456         ");
        add_gap();
        add_vector("swi_al",     32'hEF00ABCD, "SWI AL  #00ABCD         ");
        add_vector("swi_eq",     32'h0F123456, "SWI EQ  #123456         ");
        add_gap();

        // Multiplies
        add_vector("mul",        32'hE0010392, "MUL AL  R1  R2  R3      ");
        add_vector("muls",       32'h10140695, "MULSNE  R4  R5  R6      ");
        add_vector("mla",        32'h0027899A, "MLA EQ  R7  R10 R9  R8  ");
        add_vector("mlas",       32'hE03CED9B, "MLASAL  R12 R11 SP  LR  ");
        add_gap();
        add_gap();

        // Undefined words show the whole word
        add_vector("und_nv",     32'hF2012345, "UND     #F2012345       ");
        add_vector("und_regsh",  32'hE0810312, "UND     #E0810312       ");
        add_gap();
        add_vector("und_tst_ns", 32'hE10F0000, "UND     #E10F0000       ");
        add_vector("und_ldr",    32'hE5910000, "UND     #E5910000       ");
        add_gap();
        add_vector("and_again",  32'hE20120FF, "AND AL  R2  R1  #0FF    ");
endtask

`endif

// ==== tb_arm_disasm.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_arm_disasm;

        import arm_isa_pkg::*;
        import disasm_text_pkg::*;

        localparam int RESET_CYCLES = 8;
        localparam int SLACK_CYCLES = 20;

        logic                   clk;
        logic                   reset;
        instr_word_u            instruction;
        logic                   dav;
        disasm_line_t           text;
        logic                   text_valid;

        // Stimulus table, one entry per cycle
        string                  vec_name[$];
        logic [INSTR_W-1:0]     vec_word[$];
        logic                   vec_dav[$];
        disasm_line_t           vec_line[$];

        // Lines still in the pipeline
        string                  name_q[$];
        disasm_line_t           line_q[$];

        // Last line taken from the DUT, held over idle cycles
        disasm_line_t           last_line;
        logic                   line_seen;

        // Valid input delayed by the two pipeline stages
        logic                   dav_d1;
        logic                   dav_d2;
        int                     cycles;
        int                     cycle_limit;

        arm_disasm_top dut0
        (
                .i_clk          (clk),
                .i_reset        (reset),
                .i_instruction  (instruction),
                .i_dav          (dav),
                .o_text         (text),
                .o_text_valid   (text_valid)
        );

        task automatic add_vector(input string name, input logic [INSTR_W-1:0] word,
                                  input disasm_line_t line);
                vec_name.push_back(name);
                vec_word.push_back(word);
                vec_dav.push_back(1'b1);
                vec_line.push_back(line);
        endtask

        task automatic add_gap();
                vec_name.push_back("gap");
                vec_word.push_back(32'hDEAD_BEEF);
                vec_dav.push_back(1'b0);
                vec_line.push_back({LINE_CHARS{ASCII_SPACE}});
        endtask

        `include "tb_vectors.svh"

        task automatic stop_on_failure();
                $display("RESULT: FAIL");
                $fatal(1, "Simulation stopped at first error");
        endtask

        task automatic drive_word(input logic [INSTR_W-1:0] word, input logic valid);
                instruction.raw = word;
                dav             = valid;
                dav_d1          = valid;
        endtask

        // Called on the falling edge, after the outputs have settled
        task automatic check_output();
                string          name;
                disasm_line_t   expected;

                assert (text_valid === dav_d2)
                else
                begin
                        $display("** Error valid_timing: expected %b, actual %b",
                                 dav_d2, text_valid);
                        stop_on_failure();
                end
                if (text_valid === 1'b1)
                begin
                        assert (line_q.size() > 0)
                        else
                        begin
                                $display("Output line appeared with no line expected");
                                stop_on_failure();
                        end
                        name     = name_q.pop_front();
                        expected = line_q.pop_front();
                        assert (text === expected)
                        else
                        begin
                                $display("** Error %s: expected \"%s\", actual \"%s\"",
                                         name, expected, text);
                                stop_on_failure();
                        end
                        last_line = text;
                        line_seen = 1'b1;
                end
                else if (line_seen)
                begin
                        // Idle cycles keep the previous line
                        assert (text === last_line)
                        else
                        begin
                                $display("** Error hold_line: expected \"%s\", actual \"%s\"",
                                         last_line, text);
                                stop_on_failure();
                        end
                end
                dav_d2 = dav_d1;
        endtask

        // ----------------------------------------
        // Clock and timeout
        // ----------------------------------------

        initial
        begin
                clk = 1'b0;
                forever #50 clk = ~clk;
        end

        always @(posedge clk)
        begin
                cycles = cycles + 1;
                if (cycles > cycle_limit)
                begin
                        $display("Timeout after %0d cycles, pipeline did not drain", cycles);
                        stop_on_failure();
                end
        end

        // ----------------------------------------
        // Stimulus and checks
        // ----------------------------------------

        initial
        begin
                reset       = 1'b1;
                dav         = 1'b0;
                instruction = '0;
                dav_d1      = 1'b0;
                dav_d2      = 1'b0;
                last_line   = '0;
                line_seen   = 1'b0;
                cycles      = 0;
                fill_table();
                cycle_limit = vec_dav.size() + RESET_CYCLES + SLACK_CYCLES;

                repeat (RESET_CYCLES) @(negedge clk);
                reset = 1'b0;

                for (int i = 0; i < vec_dav.size(); i++)
                begin
                        @(negedge clk);
                        check_output();
                        drive_word(vec_word[i], vec_dav[i]);
                        if (vec_dav[i])
                        begin
                                name_q.push_back(vec_name[i]);
                                line_q.push_back(vec_line[i]);
                        end
                end

                // Let the last words leave the pipeline
                while (dav_d1 || dav_d2)
                begin
                        @(negedge clk);
                        check_output();
                        drive_word('0, 1'b0);
                end

                if (line_q.size() != 0 || name_q.size() != 0)
                begin
                        $display("Expected lines never came out of the DUT");
                        stop_on_failure();
                end
                else
                begin
                        $display("RESULT: PASS");
                        $finish;
                end
        end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+.
arm_isa_pkg.sv
disasm_text_pkg.sv
instr_classify.sv
mnemonic_formatter.sv
operand_formatter.sv
text_assembler.sv
arm_disasm_top.sv
tb_arm_disasm.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the ARM disassembler testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
        -f sim.f --top-module tb_arm_disasm -Mdir obj_dir -o tb_arm_disasm
if [ $? -ne 0 ]; then
        echo "Verilator build failed"
        exit 1
fi

./obj_dir/tb_arm_disasm > sim.log 2>&1
run_status=$?
cat sim.log

# The log decides the outcome
if grep -q "RESULT: FAIL" sim.log; then
        echo "Simulation reported a failure"
        exit 1
fi

if [ $run_status -ne 0 ]; then
        echo "Simulation exited with status $run_status"
        exit 1
fi

echo "Simulation finished without failure"
exit 0
